//--- files.f
+incdir+tb
src/simt_pkg.sv
src/issue_slot.sv
src/alu_lane.sv
src/result_stage.sv
src/simt_exec_unit.sv
tb/tb_simt_exec.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps \
    -f files.f --top-module tb_simt_exec -Mdir obj_dir -o sim

# tee keeps the log even when the run stops early
./obj_dir/sim | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1

//--- tb/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// expected response of one warp instruction
typedef struct packed {
    logic                   is_branch;
    warp_id_t               warp;
    logic [LANES-1:0]       mask;
    logic [DST_W-1:0]       dst;
    logic [SCB_W-1:0]       scb_id;
    data_word_t [LANES-1:0] data;
    logic [LANES-1:0]       taken;
    data_word_t             target;
} exp_t;

function automatic instr_u alu_instr(logic [3:0] op, logic [DST_W-1:0] dst, logic imm_valid,
                                     logic [15:0] imm);
    instr_u w;
    w               = '0;
    w.alu.alu_op    = alu_op_e'(op);  // 8..15 go in as raw codes
    w.alu.dst       = dst;
    w.alu.imm_valid = imm_valid;
    w.alu.imm       = imm;
    return w;
endfunction

function automatic instr_u br_instr(logic cond_lt, logic [SCB_W-1:0] scb_id, logic [15:0] offset);
    instr_u w;
    w              = '0;
    w.br.is_branch = 1'b1;
    w.br.cond_lt   = cond_lt;
    w.br.scb_id    = scb_id;
    w.br.offset    = offset;
    return w;
endfunction

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////

function automatic exp_t exec_ref(warp_id_t warp, logic [LANES-1:0] mask, instr_u instr,
                                  data_word_t [LANES-1:0] src1, data_word_t [LANES-1:0] src2);
    exp_t               e;
    logic [3:0]         op;
    data_word_t         b;
    logic signed [31:0] x;
    logic signed [31:0] y;
    e           = '0;
    e.is_branch = instr.br.is_branch;
    e.warp      = warp;
    e.mask      = mask;
    op          = instr.alu.alu_op;
    if (e.is_branch) begin
        e.scb_id = instr.br.scb_id;
        e.target = {16'h0000, instr.br.offset} * 32'd4;  // byte address of the word offset
        for (int i = 0; i < LANES; i++) begin
            if (instr.br.cond_lt)
                e.taken[i] = mask[i] && ($signed(src1[i][15:0]) < $signed(src2[i][15:0]));
            else
                e.taken[i] = mask[i] && (src1[i] == src2[i]);
        end
    end else begin
        e.dst = instr.alu.dst;
        for (int i = 0; i < LANES; i++) begin
            x = 32'($signed(src1[i][15:0]));
            y = 32'($signed(src2[i][15:0]));
            b = src2[i];
            // immediate only for add and the logic ops
            if (instr.alu.imm_valid && (op == 4'd0 || (op >= 4'd3 && op <= 4'd5)))
                b = 32'($signed(instr.alu.imm));
            case (op)
                4'd0:    e.data[i] = src1[i] + b;
                4'd1:    e.data[i] = src1[i] - src2[i];
                4'd2:    e.data[i] = x * y;
                4'd3:    e.data[i] = src1[i] & b;
                4'd4:    e.data[i] = src1[i] | b;
                4'd5:    e.data[i] = src1[i] ^ b;
                4'd6:    e.data[i] = src1[i] >> (src2[i] % 32);
                4'd7:    e.data[i] = src1[i] << (src2[i] % 32);
                default: e.data[i] = '0;
            endcase
        end
    end
    return e;
endfunction

`endif

//--- tb/tb_simt_exec.sv
module tb_simt_exec
    import simt_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LANES   = 8;
    localparam int TIMEOUT = 500;  // cycles per wait loop

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   oc_req;
    logic                   oc_ack;
    warp_id_t               oc_warp;
    logic [LANES-1:0]       oc_mask;
    instr_u                 oc_instr;
    data_word_t [LANES-1:0] oc_src1;
    data_word_t [LANES-1:0] oc_src2;
    logic                   res_req;
    logic                   res_ack;
    logic                   res_is_branch;
    warp_id_t               res_warp;
    logic [LANES-1:0]       res_mask;
    logic [DST_W-1:0]       res_dst;
    data_word_t [LANES-1:0] res_data;
    logic [LANES-1:0]       res_taken;
    data_word_t             res_target;
    logic                   scb_clr;
    warp_id_t               scb_clr_warp;
    logic [SCB_W-1:0]       scb_clr_id;

    `include "exec_model.svh"

    exp_t  exp_q[$];           // issue order
    string name_q[$];
    int    n_sent        = 0;
    int    issued        = 0;  // oc_ack rises
    int    retired       = 0;  // res_req falls
    int    ack_delay_max = 3;
    logic  ack_q         = 1'b0;
    logic  req_q         = 1'b0;

    simt_exec_unit #(.LANES(LANES)) i_simt_exec_unit (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // error reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(string test, string field, string exp, string act);
        stop_on_error($sformatf("mismatch %s %s: expected %s, actual %s", test, field, exp, act));
    endtask

    task automatic check_word(string test, string field, data_word_t exp, data_word_t act);
        if (act !== exp)
            report_mismatch(test, field, $sformatf("%h", exp), $sformatf("%h", act));
    endtask
    task automatic check_mask(string test, string field, logic [LANES-1:0] exp,
                              logic [LANES-1:0] act);
        if (act !== exp)
            report_mismatch(test, field, $sformatf("%b", exp), $sformatf("%b", act));
    endtask
    task automatic check_warp(string test, string field, warp_id_t exp, warp_id_t act);
        if (act !== exp)
            report_mismatch(test, field, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask
    task automatic check_dst(string test, string field, logic [DST_W-1:0] exp,
                             logic [DST_W-1:0] act);
        if (act !== exp)
            report_mismatch(test, field, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask
    task automatic check_scb(string test, string field, logic [SCB_W-1:0] exp,
                             logic [SCB_W-1:0] act);
        if (act !== exp)
            report_mismatch(test, field, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask
    task automatic check_flag(string test, string field, logic exp, logic act);
        if (act !== exp)
            report_mismatch(test, field, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    //////////////////////////////////////////////////
    // collector side four-phase handshake
    //////////////////////////////////////////////////

    task automatic issue(string name, instr_u instr);
        data_word_t [LANES-1:0] s1;
        data_word_t [LANES-1:0] s2;
        warp_id_t               w;
        logic [LANES-1:0]       m;
        int                     t;
        w = warp_id_t'($urandom);
        m = LANES'($urandom);
        for (int i = 0; i < LANES; i++) begin
            s1[i] = $urandom;
            s2[i] = $urandom;  // shift amounts mostly above 31
            case ($urandom_range(3, 0))
                0:       s2[i] = s1[i];              // forced equal
                1:       s2[i][15:0] = s1[i][15:0];  // equal low halves only
                default: ;
            endcase
        end
        s1[0][15] = 1'b1;  // negative multiplicands
        s2[1][15] = 1'b1;
        t = 0;
        while (oc_ack) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) stop_on_error("oc_ack stayed high after oc_req was dropped");
        end
        {oc_warp, oc_mask, oc_instr, oc_src1, oc_src2} = {w, m, instr, s1, s2};
        oc_req = 1'b1;
        exp_q.push_back(exec_ref(w, m, instr, s1, s2));
        name_q.push_back(name);
        n_sent++;
        t = 0;
        while (!oc_ack) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) stop_on_error("oc_ack never answered oc_req");
        end
        oc_req   = 1'b0;
        oc_instr = instr_u'($urandom);  // junk once the slot has it
    endtask

    //////////////////////////////////////////////////
    // consumer and compare
    //////////////////////////////////////////////////

    initial begin
        int delay;
        int t;
        res_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (res_req) begin
                delay = $urandom_range(ack_delay_max, 0);
                repeat (delay) @(negedge clk);
                res_ack = 1'b1;
                t = 0;
                while (res_req) begin
                    @(negedge clk);
                    t++;
                    if (t > TIMEOUT) stop_on_error("res_req did not drop after res_ack");
                end
                res_ack = 1'b0;
            end
        end
    end

    task automatic compare_result();
        exp_t  e;
        string nm;
        if (exp_q.size() == 0) begin
            stop_on_error("a result appeared with no instruction issued");
        end else begin
            e  = exp_q.pop_front();
            nm = name_q.pop_front();
            check_flag(nm, "res_is_branch", e.is_branch, res_is_branch);
            check_warp(nm, "res_warp", e.warp, res_warp);
            check_mask(nm, "res_mask", e.mask, res_mask);
            check_mask(nm, "res_taken", e.taken, res_taken);
            check_flag(nm, "scb_clr", e.is_branch, scb_clr);  // same edge as the load
            for (int i = 0; i < LANES; i++) begin
                check_word(nm, $sformatf("res_data[%0d]", i), e.data[i], res_data[i]);
            end
            if (e.is_branch) begin
                check_word(nm, "res_target", e.target, res_target);
                check_warp(nm, "scb_clr_warp", e.warp, scb_clr_warp);
                check_scb(nm, "scb_clr_id", e.scb_id, scb_clr_id);
            end else begin
                check_dst(nm, "res_dst", e.dst, res_dst);
            end
        end
    endtask

    // registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (oc_ack !== 1'b0 || res_req !== 1'b0 || scb_clr !== 1'b0)
                stop_on_error("oc_ack, res_req or scb_clr high during reset");
        end else begin
            if (oc_ack && !ack_q) begin
                if (issued >= n_sent)
                    stop_on_error("oc_ack rose with no request pending");
                if (issued - retired >= 2)
                    stop_on_error("oc_ack rose while both stages were full");
                issued++;
            end
            if (!res_req && req_q)
                retired++;
            if (res_req && !req_q)
                compare_result();
            else if (scb_clr)
                stop_on_error("scb_clr pulsed without a new branch result");
        end
        ack_q = oc_ack;
        req_q = res_req;
    end

    //////////////////////////////////////////////////
    // scenarios
    //////////////////////////////////////////////////

    initial begin
        int t;
        void'($urandom(32'hdf541849));
        rst = 1'b0;
        {oc_req, oc_warp, oc_mask, oc_instr, oc_src1, oc_src2} = '0;
        repeat (4) @(negedge clk);
        oc_req = 1'b1;  // must not be taken while in reset
        repeat (4) @(negedge clk);
        oc_req = 1'b0;
        rst    = 1'b1;
        repeat (4) @(negedge clk);  // idle after reset

        for (int op = 0; op < 16; op++) begin
            repeat (3) issue("reg_ops", alu_instr(4'(op), DST_W'($urandom), 1'b0, 16'($urandom)));
        end
        // negative immediates that sub, mul and the shifts ignore
        for (int op = 0; op < 8; op++) begin
            repeat (3) begin
                issue("imm_ops", alu_instr(4'(op), DST_W'($urandom), 1'b1,
                                           16'($urandom) | 16'h8000));
            end
        end
        repeat (40) issue("branches", br_instr(1'($urandom), SCB_W'($urandom), 16'($urandom)));

        ack_delay_max = 24;  // slow consumer
        repeat (40) begin
            if ($urandom_range(1, 0) == 1) begin
                issue("backpressure", br_instr(1'($urandom), SCB_W'($urandom), 16'($urandom)));
            end else begin
                issue("backpressure", alu_instr(4'($urandom), DST_W'($urandom), 1'($urandom),
                                                16'($urandom)));
            end
        end

        t = 0;
        while (retired != n_sent || exp_q.size() != 0) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) stop_on_error("results were still missing at the end of the run");
        end
        repeat (4) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- src/simt_exec_unit.sv
module simt_exec_unit
    import simt_pkg::*;
#(
    parameter int LANES = 8
) (
    input  logic                   clk,
    input  logic                   rst,

    // operand collector
    input  logic                   oc_req,
    output logic                   oc_ack,
    input  warp_id_t               oc_warp,
    input  logic [LANES-1:0]       oc_mask,
    input  instr_u                 oc_instr,
    input  data_word_t [LANES-1:0] oc_src1,
    input  data_word_t [LANES-1:0] oc_src2,

    // cdb / simt stack result
    output logic                   res_req,
    input  logic                   res_ack,
    output logic                   res_is_branch,
    output warp_id_t               res_warp,
    output logic [LANES-1:0]       res_mask,
    output logic [DST_W-1:0]       res_dst,
    output data_word_t [LANES-1:0] res_data,
    output logic [LANES-1:0]       res_taken,
    output data_word_t             res_target,

    // scoreboard
    output logic                   scb_clr,
    output warp_id_t               scb_clr_warp,
    output logic [SCB_W-1:0]       scb_clr_id
);

    logic                   slot_valid;
    logic                   slot_take;
    warp_id_t               slot_warp;
    logic [LANES-1:0]       slot_mask;
    data_word_t [LANES-1:0] slot_src1;
    data_word_t [LANES-1:0] slot_src2;
    logic                   slot_is_branch;
    alu_op_e                slot_alu_op;
    logic                   slot_imm_valid;
    logic [15:0]            slot_imm;
    logic [DST_W-1:0]       slot_dst;
    logic                   slot_cond_lt;
    logic [SCB_W-1:0]       slot_scb_id;
    data_word_t [LANES-1:0] lane_data;
    logic [LANES-1:0]       lane_taken;

    issue_slot #(.LANES(LANES)) i_issue_slot (
        .clk            (clk),
        .rst            (rst),
        .oc_req         (oc_req),
        .oc_warp        (oc_warp),
        .oc_mask        (oc_mask),
        .oc_instr       (oc_instr),
        .oc_src1        (oc_src1),
        .oc_src2        (oc_src2),
        .oc_ack         (oc_ack),
        .slot_take      (slot_take),
        .slot_valid     (slot_valid),
        .slot_warp      (slot_warp),
        .slot_mask      (slot_mask),
        .slot_src1      (slot_src1),
        .slot_src2      (slot_src2),
        .slot_is_branch (slot_is_branch),
        .slot_alu_op    (slot_alu_op),
        .slot_imm_valid (slot_imm_valid),
        .slot_imm       (slot_imm),
        .slot_dst       (slot_dst),
        .slot_cond_lt   (slot_cond_lt),
        .slot_scb_id    (slot_scb_id)
    );

    // one lane per thread of the warp
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        alu_lane i_alu_lane (
            .is_branch (slot_is_branch),
            .alu_op    (slot_alu_op),
            .imm_valid (slot_imm_valid),
            .imm       (slot_imm),
            .cond_lt   (slot_cond_lt),
            .src1      (slot_src1[i]),
            .src2      (slot_src2[i]),
            .active    (slot_mask[i]),
            .data      (lane_data[i]),
            .taken     (lane_taken[i])
        );
    end

    result_stage #(.LANES(LANES)) i_result_stage (
        .clk            (clk),
        .rst            (rst),
        .slot_valid     (slot_valid),
        .slot_warp      (slot_warp),
        .slot_mask      (slot_mask),
        .slot_is_branch (slot_is_branch),
        .slot_dst       (slot_dst),
        .slot_imm       (slot_imm),
        .slot_scb_id    (slot_scb_id),
        .slot_take      (slot_take),
        .lane_data      (lane_data),
        .lane_taken     (lane_taken),
        .res_req        (res_req),
        .res_ack        (res_ack),
        .res_is_branch  (res_is_branch),
        .res_warp       (res_warp),
        .res_mask       (res_mask),
        .res_dst        (res_dst),
        .res_data       (res_data),
        .res_taken      (res_taken),
        .res_target     (res_target),
        .scb_clr        (scb_clr),
        .scb_clr_warp   (scb_clr_warp),
        .scb_clr_id     (scb_clr_id)
    );

endmodule

//--- src/result_stage.sv
module result_stage
    import simt_pkg::*;
#(
    parameter int LANES = 8
) (
    input  logic                   clk,
    input  logic                   rst,

    // from the issue slot
    input  logic                   slot_valid,
    input  warp_id_t               slot_warp,
    input  logic [LANES-1:0]       slot_mask,
    input  logic                   slot_is_branch,
    input  logic [DST_W-1:0]       slot_dst,
    input  logic [15:0]            slot_imm,
    input  logic [SCB_W-1:0]       slot_scb_id,
    output logic                   slot_take,

    // from the lane array
    input  data_word_t [LANES-1:0] lane_data,
    input  logic [LANES-1:0]       lane_taken,

    // result, four-phase
    output logic                   res_req,
    input  logic                   res_ack,
    output logic                   res_is_branch,
    output warp_id_t               res_warp,
    output logic [LANES-1:0]       res_mask,
    output logic [DST_W-1:0]       res_dst,
    output data_word_t [LANES-1:0] res_data,
    output logic [LANES-1:0]       res_taken,
    output data_word_t             res_target,

    // scoreboard clear, one cycle per branch
    output logic                   scb_clr,
    output warp_id_t               scb_clr_warp,
    output logic [SCB_W-1:0]       scb_clr_id
);

    localparam logic [1:0] ST_EMPTY   = 2'd0;
    localparam logic [1:0] ST_FULL    = 2'd1;  // req up, waiting for ack
    localparam logic [1:0] ST_RELEASE = 2'd2;  // req down, waiting for ack low

    logic [1:0]       state;
    logic [SCB_W-1:0] scb_id_q;
    data_word_t       br_target;

    assign slot_take = slot_valid & (state == ST_EMPTY);
    assign res_req   = (state == ST_FULL);

    // offset is in words
    assign br_target = slot_is_branch ? {{(DATA_W-18){1'b0}}, slot_imm, 2'b00} : '0;

    //////////////////////////////////////////////////
    // output handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= ST_EMPTY;
            scb_clr <= 1'b0;
        end else begin
            scb_clr <= slot_take & slot_is_branch;  // drops the next cycle
            case (state)
                ST_EMPTY:   if (slot_valid) state <= ST_FULL;
                ST_FULL:    if (res_ack) state <= ST_RELEASE;
                ST_RELEASE: if (!res_ack) state <= ST_EMPTY;
                default:    state <= ST_EMPTY;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // result register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (slot_take) begin
            res_is_branch <= slot_is_branch;
            res_warp      <= slot_warp;
            res_mask      <= slot_mask;
            res_dst       <= slot_dst;
            res_data      <= lane_data;
            res_taken     <= lane_taken;
            res_target    <= br_target;
            scb_id_q      <= slot_scb_id;
        end
    end

    assign scb_clr_warp = res_warp;
    assign scb_clr_id   = scb_id_q;

endmodule

//--- src/alu_lane.sv
module alu_lane
    import simt_pkg::*;
(
    input  logic        is_branch,
    input  alu_op_e     alu_op,
    input  logic        imm_valid,
    input  logic [15:0] imm,
    input  logic        cond_lt,
    input  data_word_t  src1,
    input  data_word_t  src2,
    input  logic        active,   // lane bit of the warp mask
    output data_word_t  data,
    output logic        taken
);

    data_word_t         imm_ext;
    data_word_t         opnd_b;   // src2 or immediate
    data_word_t         alu_res;
    logic signed [15:0] lo1;
    logic signed [15:0] lo2;
    logic signed [31:0] product;
    logic               is_eq;
    logic               is_lt;

    //////////////////////////////////////////////////
    // operands
    //////////////////////////////////////////////////

    assign imm_ext = {{(DATA_W-16){imm[15]}}, imm};
    assign opnd_b  = imm_valid ? imm_ext : src2;

    // low halves, shared by mul and blt
    assign lo1     = src1[15:0];
    assign lo2     = src2[15:0];
    assign product = lo1 * lo2;

    //////////////////////////////////////////////////
    // arithmetic
    //////////////////////////////////////////////////

    always_comb begin
        case (alu_op)
            OP_ADD:  alu_res = src1 + opnd_b;
            OP_SUB:  alu_res = src1 - src2;       // no immediate form
            OP_MUL:  alu_res = product;
            OP_AND:  alu_res = src1 & opnd_b;
            OP_OR:   alu_res = src1 | opnd_b;
            OP_XOR:  alu_res = src1 ^ opnd_b;
            OP_SHR:  alu_res = src1 >> src2[4:0];
            OP_SHL:  alu_res = src1 << src2[4:0];
            default: alu_res = '0;                 // codes 8..15
        endcase
    end

    //////////////////////////////////////////////////
    // branch compare
    //////////////////////////////////////////////////

    assign is_eq = (src1 == src2);  // full word
    assign is_lt = (lo1 < lo2);     // signed low 16

    // inactive lanes never branch
    assign taken = is_branch & active & (cond_lt ? is_lt : is_eq);

    assign data  = is_branch ? '0 : alu_res;

endmodule

//--- src/issue_slot.sv
module issue_slot
    import simt_pkg::*;
#(
    parameter int LANES = 8
) (
    input  logic                   clk,
    input  logic                   rst,

    // operand collector, four-phase
    input  logic                   oc_req,
    input  warp_id_t               oc_warp,
    input  logic [LANES-1:0]       oc_mask,
    input  instr_u                 oc_instr,
    input  data_word_t [LANES-1:0] oc_src1,
    input  data_word_t [LANES-1:0] oc_src2,
    output logic                   oc_ack,

    // held instruction toward lanes and result stage
    input  logic                   slot_take,
    output logic                   slot_valid,
    output warp_id_t               slot_warp,
    output logic [LANES-1:0]       slot_mask,
    output data_word_t [LANES-1:0] slot_src1,
    output data_word_t [LANES-1:0] slot_src2,
    output logic                   slot_is_branch,
    output alu_op_e                slot_alu_op,
    output logic                   slot_imm_valid,
    output logic [15:0]            slot_imm,
    output logic [DST_W-1:0]       slot_dst,
    output logic                   slot_cond_lt,
    output logic [SCB_W-1:0]       slot_scb_id
);

    logic   capture;
    instr_u instr_q;

    // new request only once ack has dropped and the slot is free
    assign capture = oc_req & ~oc_ack & ~slot_valid;

    //////////////////////////////////////////////////
    // handshake and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            oc_ack     <= 1'b0;
            slot_valid <= 1'b0;
        end else begin
            if (capture) begin
                oc_ack <= 1'b1;
            end else if (!oc_req) begin
                oc_ack <= 1'b0;  // collector released req
            end

            if (capture) begin
                slot_valid <= 1'b1;
            end else if (slot_take) begin
                slot_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // input register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (capture) begin
            instr_q   <= oc_instr;
            slot_warp <= oc_warp;
            slot_mask <= oc_mask;
            slot_src1 <= oc_src1;
            slot_src2 <= oc_src2;
        end
    end

    // decode, alu view for op/dst/imm and branch view for cond/scb
    assign slot_is_branch = instr_q.alu.is_branch;
    assign slot_alu_op    = instr_q.alu.alu_op;
    assign slot_dst       = instr_q.alu.dst;
    assign slot_imm_valid = instr_q.alu.imm_valid;
    assign slot_imm       = instr_q.alu.imm;  // also the branch offset
    assign slot_cond_lt   = instr_q.br.cond_lt;
    assign slot_scb_id    = instr_q.br.scb_id;

endmodule

//--- src/simt_pkg.sv
package simt_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int DATA_W = 32;  // lane word
    localparam int WARP_W = 3;   // 8 warps
    localparam int DST_W  = 5;   // destination register number
    localparam int SCB_W  = 2;   // scoreboard entry id

    typedef logic [DATA_W-1:0] data_word_t;
    typedef logic [WARP_W-1:0] warp_id_t;

    //////////////////////////////////////////////////
    // alu opcodes
    //////////////////////////////////////////////////

    // codes 8..15 are legal and give a zero result
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_MUL = 4'd2,  // signed low halves
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_SHR = 4'd6,  // logical
        OP_SHL = 4'd7
    } alu_op_e;

    //////////////////////////////////////////////////
    // instruction word, two views
    //////////////////////////////////////////////////

    // alu format, is_branch = 0
    typedef struct packed {
        logic             is_branch;  // bit 31
        alu_op_e          alu_op;
        logic [DST_W-1:0] dst;
        logic             imm_valid;
        logic [4:0]       pad;
        logic [15:0]      imm;        // sign-extended in the lane
    } alu_fmt_t;

    // branch format, is_branch = 1
    typedef struct packed {
        logic             is_branch;  // bit 31
        logic             cond_lt;    // 0 beq, 1 blt
        logic [SCB_W-1:0] scb_id;
        logic [11:0]      pad;
        logic [15:0]      offset;     // word offset, target is offset*4
    } br_fmt_t;

    // same 32 bits, decoded by the is_branch bit
    typedef union packed {
        alu_fmt_t alu;
        br_fmt_t  br;
    } instr_u;

endpackage
